/* dv/uart_dbg_vectors.txt */
# Columns: kind, then fields. T name starts a test, E ends it, X hex64 expects an exec address
# S n hex sends n bytes, R n hex expects n reply bytes, first byte leftmost
T reset_ack
S 1 06
R 1 06
E
T write_read
S 17 1210000000000000000400000000000000
R 1 06
S 4 a1b2c3d4
R 1 04
S 17 1110000000000000000400000000000000
R 6 06a1b2c3d404
E
T addr_wrap
S 17 12ff010000000000000100000000000000
R 1 06
S 1 5a
R 1 04
S 17 11ff000000000000000100000000000000
R 3 065a04
E
T zero_len
S 17 1120000000000000000000000000000000
R 2 0604
E
T exec
S 9 133412008000000000
R 1 06
X 0000000080001234
E
T unknown_byte
S 1 55
S 1 06
R 1 06
E

/* all.f */
hw/uart_dbg_pkg.sv
hw/dbg_mem_if.sv
hw/uart_rx_deser.sv
hw/dbg_cmd_engine.sv
hw/dbg_byte_mem.sv
hw/uart_tx_ser.sv
hw/uart_dbg_top.sv
dv/tb_clk_gen.sv
dv/uart_dbg_checker.sv
dv/tb_uart_dbg.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := tb_uart_dbg
FLIST := all.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/tb_uart_dbg.sv */
// Testbench top that replays vector records over the serial line and tallies test results
module tb_uart_dbg;
  import uart_dbg_pkg::*;

  // Wait limits in clock cycles
  localparam int reply_timeout = 2000;
  localparam int reset_timeout = 100;
  localparam int quiet_cycles  = 200;

  logic         clk;
  logic         arst_n;
  logic         uart_rx;
  logic         uart_tx;
  logic         exec_valid;
  dbg_addr_t    exec_addr;
  int           fd;
  string        line;
  string        kind;
  string        test_name;
  int           count;
  logic [255:0] data;
  dbg_addr_t    xaddr;
  int           err_start;
  int           n_tests;
  int           n_fail;
  bit           aborted;

  tb_clk_gen u_clk (
    .clk      ( clk    ),
    .arst_n_o ( arst_n )
  );

  uart_dbg_top UUT (
    .clk          ( clk        ),
    .arst_n_i     ( arst_n     ),
    .uart_rx_i    ( uart_rx    ),
    .uart_tx_o    ( uart_tx    ),
    .exec_valid_o ( exec_valid ),
    .exec_addr_o  ( exec_addr  )
  );

  uart_dbg_checker u_chk (
    .clk          ( clk        ),
    .arst_n_i     ( arst_n     ),
    .tx_i         ( uart_tx    ),
    .exec_valid_i ( exec_valid ),
    .exec_addr_i  ( exec_addr  )
  );

  // One 8N1 frame sent LSB first from a rising edge
  task automatic send_byte(input byte_t b);
    logic [frame_bits-1:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < frame_bits; i++) begin
      uart_rx <= frame[0];
      frame = frame >> 1;
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  task automatic wait_replies();
    int cycles;
    cycles = 0;
    while (u_chk.bytes_left() + u_chk.execs_left() != 0 && cycles < reply_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (u_chk.bytes_left() + u_chk.execs_left() != 0) begin
      $display("Timeout in test %s: %0d reply bytes and %0d exec pulses did not arrive",
               test_name, u_chk.bytes_left(), u_chk.execs_left());
      aborted = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector replay
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    uart_rx   <= 1'b1;
    aborted   = 1'b0;
    n_tests   = 0;
    n_fail    = 0;
    test_name = "reset";
    void'($urandom(32'ha4e404bd));
    fd        = $fopen("dv/uart_dbg_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file dv/uart_dbg_vectors.txt");
      aborted = 1'b1;
    end
    for (int i = 0; i < reset_timeout && arst_n !== 1'b1; i++) begin
      @(posedge clk);
    end
    if (arst_n !== 1'b1) begin
      $display("Reset was never released");
      aborted = 1'b1;
    end
    // The checker flags any stray frame or exec pulse on the idle line
    repeat (quiet_cycles) @(posedge clk);
    while (!aborted && $fgets(line, fd) != 0) begin
      if ($sscanf(line, "%s", kind) != 1 || kind.getc(0) == "#") begin
        continue;
      end
      if (kind == "T") begin
        void'($sscanf(line, "%s %s", kind, test_name));
        err_start = u_chk.errors;
        n_tests++;
      end else if (kind == "S") begin
        void'($sscanf(line, "%s %d %h", kind, count, data));
        wait_replies();
        for (int k = 0; k < count && !aborted; k++) begin
          repeat (1 + $urandom % 8) @(posedge clk);
          send_byte(byte_t'(data >> (8 * (count - 1 - k))));
        end
      end else if (kind == "R") begin
        void'($sscanf(line, "%s %d %h", kind, count, data));
        for (int k = 0; k < count; k++) begin
          u_chk.expect_byte(byte_t'(data >> (8 * (count - 1 - k))));
        end
      end else if (kind == "X") begin
        void'($sscanf(line, "%s %h", kind, xaddr));
        u_chk.queue_exec(xaddr);
      end else if (kind == "E") begin
        wait_replies();
        if (!aborted) begin
          repeat (quiet_cycles) @(posedge clk);
          if (u_chk.errors != err_start) begin
            n_fail++;
            $display("Test %s failed", test_name);
          end else begin
            $display("Test %s passed", test_name);
          end
        end
      end else begin
        $display("Unknown record kind %s in the vector file", kind);
        aborted = 1'b1;
      end
    end
    if (aborted) begin
      n_fail++;
      $display("Test %s did not finish", test_name);
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("Tests run %0d, failed %0d, check errors %0d", n_tests, n_fail, u_chk.errors);
    if (!aborted && n_tests > 0 && n_fail == 0 && u_chk.errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* dv/uart_dbg_checker.sv */
// Monitor that decodes the transmit line and exec pulses and compares them with expectations
module uart_dbg_checker (
  input logic                    clk,
  input logic                    arst_n_i,
  input logic                    tx_i,
  input logic                    exec_valid_i,
  input uart_dbg_pkg::dbg_addr_t exec_addr_i
);
  import uart_dbg_pkg::*;

  byte_t                 exp_bytes [$];
  dbg_addr_t             exp_execs [$];
  int                    errors = 0;
  logic                  busy = 1'b0;
  int                    cnt;
  int                    bit_idx;
  logic [frame_bits-1:0] frame;

  task automatic expect_byte(input byte_t b);
    exp_bytes.push_back(b);
  endtask

  task automatic queue_exec(input dbg_addr_t a);
    exp_execs.push_back(a);
  endtask

  function automatic int bytes_left();
    return exp_bytes.size();
  endfunction

  function automatic int execs_left();
    return exp_execs.size();
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison against the expected reply stream
  ////////////////////////////////////////////////////////////////////////////

  task automatic score_frame();
    byte_t got;
    byte_t exp;
    got = frame[8:1];
    if (frame[0] != 1'b0 || frame[frame_bits-1] != 1'b1) begin
      errors++;
      $display("Framing error on the transmit line at time %0t", $time);
    end else if (exp_bytes.size() == 0) begin
      errors++;
      $display("Unexpected reply byte %h on the transmit line at time %0t", got, $time);
    end else begin
      exp = exp_bytes.pop_front();
      if (got !== exp) begin
        errors++;
        $display("Fail at time %0t: reply byte expected %h, observed %h", $time, exp, got);
      end
    end
  endtask

  task automatic match_exec();
    dbg_addr_t exp;
    if (exp_execs.size() == 0) begin
      errors++;
      $display("Unexpected exec pulse with address %h at time %0t", exec_addr_i, $time);
    end else begin
      exp = exp_execs.pop_front();
      if (exec_addr_i !== exp) begin
        errors++;
        $display("Fail at time %0t: exec address expected %h, observed %h",
                 $time, exp, exec_addr_i);
      end
    end
  endtask

  // Line and exec pulse sampled on the falling edge
  always @(negedge clk) begin
    if (!arst_n_i) begin
      busy = 1'b0;
      if (!tx_i || exec_valid_i) begin
        errors++;
        $display("Transmit line low or exec pulse during reset at time %0t", $time);
      end
    end else begin
      if (exec_valid_i) begin
        match_exec();
      end
      if (!busy) begin
        // Start edge, first sample lands mid start bit
        if (!tx_i) begin
          busy    = 1'b1;
          bit_idx = 0;
          cnt     = half_bit - 1;
        end
      end else if (cnt != 0) begin
        cnt--;
      end else begin
        frame = {tx_i, frame[frame_bits-1:1]};
        cnt   = clks_per_bit - 1;
        if (bit_idx == frame_bits - 1) begin
          busy = 1'b0;
          score_frame();
        end else begin
          bit_idx++;
        end
      end
    end
  end

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset generator with a 4 unit period and a 10 cycle reset
module tb_clk_gen (
  output logic clk,
  output logic arst_n_o
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release lands on the tenth rising edge
  initial begin
    arst_n_o <= 1'b0;
    repeat (10) @(posedge clk);
    arst_n_o <= 1'b1;
  end

endmodule

/* hw/uart_dbg_top.sv */
// UART debug server top level with receiver, engine, memory and transmitter
module uart_dbg_top (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o
);
  import uart_dbg_pkg::*;

  logic  rx_valid;
  byte_t rx_data;
  logic  tx_valid;
  logic  tx_ready;
  byte_t tx_data;

  dbg_mem_if mem_bus ();

  uart_rx_deser u_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_data_o  ( rx_data   )
  );

  dbg_cmd_engine u_engine (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .rx_valid_i   ( rx_valid     ),
    .rx_data_i    ( rx_data      ),
    .mem          ( mem_bus.ctrl ),
    .tx_valid_o   ( tx_valid     ),
    .tx_ready_i   ( tx_ready     ),
    .tx_data_o    ( tx_data      ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  dbg_byte_mem u_mem (
    .clk ( clk         ),
    .mem ( mem_bus.mem )
  );

  uart_tx_ser u_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .tx_data_i  ( tx_data   ),
    .tx_o       ( uart_tx_o )
  );

endmodule

/* hw/uart_tx_ser.sv */
// UART transmitter that serializes reply bytes onto the line
module uart_tx_ser (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                tx_valid_i,
  output logic                tx_ready_o,
  input  uart_dbg_pkg::byte_t tx_data_i,
  output logic                tx_o
);
  import uart_dbg_pkg::*;

  logic                busy_q;
  bit_idx_t            bit_idx_q;
  bit_cnt_t            cnt_q;
  logic [frame_bits-2:0] shift_q;
  logic                line_q;
  logic                load;
  logic                bit_end;

  assign tx_ready_o = !busy_q;
  assign load       = tx_valid_i && !busy_q;
  assign bit_end    = busy_q && (cnt_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      bit_idx_q <= '0;
      cnt_q     <= '0;
      line_q    <= 1'b1;
    end else if (load) begin
      // Start bit goes out right away
      busy_q    <= 1'b1;
      bit_idx_q <= '0;
      cnt_q     <= bit_cnt_t'(clks_per_bit - 1);
      line_q    <= 1'b0;
    end else if (busy_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (bit_end) begin
      if (bit_idx_q == bit_idx_t'(frame_bits - 1)) begin
        busy_q <= 1'b0;  // stop bit done, line stays high
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
        cnt_q     <= bit_cnt_t'(clks_per_bit - 1);
        line_q    <= shift_q[0];
      end
    end
  end

  // Remaining frame bits, data LSB first then the stop bit
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[frame_bits-2:1]};
    end
  end

  assign tx_o = line_q;

endmodule

/* hw/dbg_byte_mem.sv */
// Byte-wide debug data memory with synchronous write and registered read
module dbg_byte_mem (
  input logic    clk,
  dbg_mem_if.mem mem
);
  import uart_dbg_pkg::*;

  byte_t ram_q [mem_depth];
  byte_t rdata_q;

  always_ff @(posedge clk) begin
    if (mem.req && mem.we) begin
      ram_q[mem.addr] <= mem.wdata;
    end
  end

  // Read data appears one cycle after the request
  always_ff @(posedge clk) begin
    if (mem.req && !mem.we) begin
      rdata_q <= ram_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

/* hw/dbg_cmd_engine.sv */
// Debug command engine that parses requests, moves data and sequences replies
module dbg_cmd_engine (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    rx_valid_i,
  input  uart_dbg_pkg::byte_t     rx_data_i,
  dbg_mem_if.ctrl                 mem,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output uart_dbg_pkg::byte_t     tx_data_o,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o
);
  import uart_dbg_pkg::*;

  engine_state_e state_q;
  engine_state_e state_d;
  cmd_e          cmd_q;
  cmd_e          cmd_d;
  hdr_idx_t      idx_q;
  hdr_idx_t      idx_d;
  dbg_addr_t     addr_q;
  dbg_addr_t     addr_d;
  dbg_addr_t     len_q;
  dbg_addr_t     len_d;
  dbg_addr_t     exec_addr_q;
  dbg_addr_t     exec_addr_d;
  dbg_addr_t     hdr_word;
  logic          rd_pend_q;
  logic          rd_pend_d;
  logic          tx_valid_q;
  logic          tx_valid_d;
  byte_t         tx_data_q;
  byte_t         tx_data_d;
  logic          tx_fire;
  logic          hdr_last;

  assign tx_fire  = tx_valid_q && tx_ready_i;
  assign hdr_last = (idx_q == hdr_idx_t'(hdr_bytes - 1));

  // Header field with the incoming byte merged in, little endian
  always_comb begin
    hdr_word = (state_q == hdr_len) ? len_q : addr_q;
    hdr_word[{idx_q, 3'b000} +: 8] = rx_data_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cmd_d       = cmd_q;
    idx_d       = idx_q;
    addr_d      = addr_q;
    len_d       = len_q;
    exec_addr_d = exec_addr_q;
    rd_pend_d   = 1'b0;
    tx_valid_d  = tx_valid_q;
    tx_data_d   = tx_data_q;
    unique case (state_q)
      idle: begin
        if (rx_valid_i) begin
          idx_d = '0;
          case (rx_data_i)
            cmd_ack: begin
              cmd_d      = cmd_ack;
              tx_valid_d = 1'b1;
              tx_data_d  = cmd_ack;
              state_d    = send_ack;
            end
            cmd_read, cmd_write: begin
              cmd_d   = cmd_e'(rx_data_i);
              state_d = hdr_addr;
            end
            cmd_exec: begin
              cmd_d   = cmd_exec;
              state_d = exec_addr;
            end
            // Unknown bytes are dropped
            default: state_d = idle;
          endcase
        end
      end
      hdr_addr, hdr_len, exec_addr: begin
        if (rx_valid_i) begin
          idx_d = hdr_last ? '0 : idx_q + 1'b1;
          if (state_q == hdr_len) begin
            len_d = hdr_word;
          end else begin
            addr_d = hdr_word;
          end
          if (hdr_last && state_q == hdr_addr) begin
            state_d = hdr_len;
          end else if (hdr_last) begin
            if (state_q == exec_addr) begin
              exec_addr_d = hdr_word;
            end
            tx_valid_d = 1'b1;
            tx_data_d  = cmd_ack;
            state_d    = send_ack;
          end
        end
      end
      send_ack: begin
        if (tx_fire) begin
          tx_valid_d = 1'b0;
          state_d    = idle;
          if (cmd_q == cmd_read || cmd_q == cmd_write) begin
            if (len_q == '0) begin
              tx_valid_d = 1'b1;
              tx_data_d  = cmd_eot;
              state_d    = send_eot;
            end else begin
              state_d = (cmd_q == cmd_read) ? read_data : write_data;
            end
          end
        end
      end
      read_data: begin
        // Fetch, then offer the byte, then wait for the transfer
        if (rd_pend_q) begin
          tx_valid_d = 1'b1;
          tx_data_d  = mem.rdata;
          addr_d     = addr_q + 1'b1;
          len_d      = len_q - 1'b1;
        end else if (tx_fire) begin
          if (len_q == '0) begin
            tx_data_d = cmd_eot;
            state_d   = send_eot;
          end else begin
            tx_valid_d = 1'b0;
          end
        end else if (!tx_valid_q) begin
          rd_pend_d = 1'b1;
        end
      end
      write_data: begin
        if (rx_valid_i) begin
          addr_d = addr_q + 1'b1;
          len_d  = len_q - 1'b1;
          if (len_q == dbg_addr_t'(1)) begin
            tx_valid_d = 1'b1;
            tx_data_d  = cmd_eot;
            state_d    = send_eot;
          end
        end
      end
      send_eot: begin
        if (tx_fire) begin
          tx_valid_d = 1'b0;
          state_d    = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= idle;
      cmd_q       <= cmd_ack;
      idx_q       <= '0;
      rd_pend_q   <= 1'b0;
      tx_valid_q  <= 1'b0;
      exec_addr_q <= '0;
    end else begin
      state_q     <= state_d;
      cmd_q       <= cmd_d;
      idx_q       <= idx_d;
      rd_pend_q   <= rd_pend_d;
      tx_valid_q  <= tx_valid_d;
      exec_addr_q <= exec_addr_d;
    end
  end

  always_ff @(posedge clk) begin
    addr_q    <= addr_d;
    len_q     <= len_d;
    tx_data_q <= tx_data_d;
  end

  // Memory port, only the low address bits select a byte
  assign mem.req   = (state_q == read_data && !tx_valid_q && !rd_pend_q) ||
                     (state_q == write_data && rx_valid_i);
  assign mem.we    = (state_q == write_data);
  assign mem.addr  = addr_q[mem_addr_width-1:0];
  assign mem.wdata = rx_data_i;

  assign tx_valid_o = tx_valid_q;
  assign tx_data_o  = tx_data_q;

  // Pulse coincides with the exec ACK handshake
  assign exec_valid_o = tx_fire && (state_q == send_ack) && (cmd_q == cmd_exec);
  assign exec_addr_o  = exec_addr_q;

endmodule

/* hw/uart_rx_deser.sv */
// UART receiver that samples the serial line and delivers whole bytes
module uart_rx_deser (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_data_o
);
  import uart_dbg_pkg::*;

  logic     rx_meta_q;
  logic     rx_sync_q;
  logic     rx_last_q;
  logic     busy_q;
  bit_idx_t bit_idx_q;
  bit_cnt_t cnt_q;
  byte_t    shift_q;
  logic     sample;
  logic     stop_bit;

  // Mid-bit sample point and position in the frame
  assign sample   = busy_q && (cnt_q == '0);
  assign stop_bit = (bit_idx_q == bit_idx_t'(frame_bits - 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q  <= 1'b1;
      rx_sync_q  <= 1'b1;
      rx_last_q  <= 1'b1;
      busy_q     <= 1'b0;
      bit_idx_q  <= '0;
      cnt_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_meta_q  <= rx_i;
      rx_sync_q  <= rx_meta_q;
      rx_last_q  <= rx_sync_q;
      rx_valid_o <= 1'b0;
      if (!busy_q) begin
        // Falling edge starts a frame, first stop lands mid start bit
        if (rx_last_q && !rx_sync_q) begin
          busy_q    <= 1'b1;
          bit_idx_q <= '0;
          cnt_q     <= bit_cnt_t'(half_bit - 1);
        end
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= bit_cnt_t'(clks_per_bit - 1);
        if (bit_idx_q == '0 && rx_sync_q) begin
          busy_q <= 1'b0;  // glitch, not a real start bit
        end else if (stop_bit) begin
          busy_q     <= 1'b0;
          rx_valid_o <= rx_sync_q;
        end else begin
          bit_idx_q <= bit_idx_q + 1'b1;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_idx_q != '0 && !stop_bit) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o = shift_q;

endmodule

/* hw/dbg_mem_if.sv */
// Byte-memory port between the command engine and the debug memory
interface dbg_mem_if;
  import uart_dbg_pkg::*;

  logic      req;
  logic      we;
  mem_addr_t addr;
  byte_t     wdata;
  // Valid the cycle after a read request
  byte_t     rdata;

  modport ctrl (
    output req, we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

/* hw/uart_dbg_pkg.sv */
// UART debug server shared constants, widths, opcodes and engine states
package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Serial line format, 8N1 with a fixed divider
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned clks_per_bit = 8;
  localparam int unsigned half_bit     = clks_per_bit / 2;
  // Start bit, eight data bits, stop bit
  localparam int unsigned frame_bits   = 10;

  typedef logic [$clog2(clks_per_bit)-1:0] bit_cnt_t;
  typedef logic [$clog2(frame_bits)-1:0]   bit_idx_t;
  typedef logic [7:0]                      byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // Debug memory and protocol fields
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned mem_addr_width = 8;
  localparam int unsigned mem_depth      = 1 << mem_addr_width;
  // Address and length fields are 8 bytes each, little endian
  localparam int unsigned hdr_bytes      = 8;

  typedef logic [mem_addr_width-1:0]    mem_addr_t;
  typedef logic [$clog2(hdr_bytes)-1:0] hdr_idx_t;
  typedef logic [63:0]                  dbg_addr_t;

  typedef enum logic [7:0] {
    cmd_eot   = 8'h04,
    cmd_ack   = 8'h06,
    cmd_read  = 8'h11,
    cmd_write = 8'h12,
    cmd_exec  = 8'h13
  } cmd_e;

  typedef enum logic [2:0] {
    idle,
    hdr_addr,
    hdr_len,
    send_ack,
    read_data,
    write_data,
    send_eot,
    exec_addr
  } engine_state_e;

endpackage
